/* fetchPkg.sv */
/*
 * Shared widths, RV32 opcodes and port structs for the dual-issue fetch unit.
 * Imported by every design module and by the testbench.
 */
`default_nettype none

package fetchPkg;

    // Datapath and index widths
    localparam int xlen        = 32;
    localparam int regAddrBits = 5;
    localparam int ghrBits     = 5;

    // Major opcodes the fetch end needs to recognise
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opRtype  = 7'b0110011;
    localparam logic [6:0] opItype  = 7'b0010011;

    // Words at pc and pc+4
    typedef struct packed {
        logic [xlen-1:0] instr0;
        logic [xlen-1:0] instr1;
    } fetchPair_t;

    typedef struct packed {
        logic [xlen-1:0]    pc;
        logic [1:0]         issueCount;
        logic               predTaken;
        logic [ghrBits-1:0] phtIndex;
    } fetchOut_t;

    // Report from the execute stage for one control instruction
    typedef struct packed {
        logic               valid;
        logic [xlen-1:0]    pc;
        logic               isBranch;
        logic               isJump;
        logic               taken;
        logic               predTaken;
        logic [xlen-1:0]    target;
        logic [ghrBits-1:0] phtIndex;
    } resolve_t;

endpackage

`default_nettype wire

/* pairCheck.sv */
/*
 * Decides whether the fetched pair can issue together or only the first word.
 * Purely combinational; the result sets how far the PC advances.
 */
`timescale 1ns/1ps
`default_nettype none

module pairCheck import fetchPkg::*; (
    input  fetchPair_t pair_i,
    output logic [1:0] issueCount_o
);

    logic [6:0]             op0;
    logic [6:0]             op1;
    logic [regAddrBits-1:0] rd0;
    logic [regAddrBits-1:0] rd1;
    logic [regAddrBits-1:0] rs1Second;
    logic [regAddrBits-1:0] rs2Second;
    logic                   control;
    logic                   raw;
    logic                   waw;
    logic                   readsRs2;

    function automatic logic writesRd(input logic [6:0] op);
        case (op)
            opLui, opJal, opJalr, opLoad, opRtype, opItype: writesRd = 1'b1;
            default: writesRd = 1'b0;
        endcase
    endfunction

    function automatic logic isControl(input logic [6:0] op);
        isControl = (op == opBranch) || (op == opJal) || (op == opJalr);
    endfunction

    // Fields sit at fixed positions in every format
    assign op0       = pair_i.instr0[6:0];
    assign op1       = pair_i.instr1[6:0];
    assign rd0       = pair_i.instr0[11:7];
    assign rd1       = pair_i.instr1[11:7];
    assign rs1Second = pair_i.instr1[19:15];
    assign rs2Second = pair_i.instr1[24:20];

    assign control  = isControl(op0) || isControl(op1);
    assign readsRs2 = (op1 == opRtype) || (op1 == opStore);

    // Second word depends on the first one's result
    assign raw = writesRd(op0) && (rd0 != '0) &&
                 ((rs1Second == rd0) || (readsRs2 && (rs2Second == rd0)));

    // Both words target the same register
    assign waw = writesRd(op0) && writesRd(op1) && (rd0 != '0) && (rd0 == rd1);

    assign issueCount_o = (control || raw || waw) ? 2'd1 : 2'd2;

endmodule

`default_nettype wire

/* patternTable.sv */
/*
 * Table of 2-bit saturating branch counters indexed by the gshare hash.
 * Asynchronous read for prediction, synchronous training from resolve.
 */
`timescale 1ns/1ps
`default_nettype none

module patternTable import fetchPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [ghrBits-1:0] readIndex_i,
    output logic               taken_o,
    input  logic               trainEn_i,
    input  logic [ghrBits-1:0] trainIndex_i,
    input  logic               trainTaken_i
);

    localparam int numEntries = 1 << ghrBits;

    logic [1:0] counters [numEntries];
    logic [1:0] current;

    // Upper bit of the counter is the direction
    assign taken_o = counters[readIndex_i][1];

    assign current = counters[trainIndex_i];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Weakly not taken
            for (int i = 0; i < numEntries; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (trainEn_i) begin
            if (trainTaken_i) begin
                if (current != 2'b11) begin
                    counters[trainIndex_i] <= current + 2'b01;
                end
            end else begin
                if (current != 2'b00) begin
                    counters[trainIndex_i] <= current - 2'b01;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* targetBuffer.sv */
/*
 * Direct-mapped branch target buffer without tags.
 * Each entry holds valid, jump bit and target; written on taken resolves.
 */
`timescale 1ns/1ps
`default_nettype none

module targetBuffer import fetchPkg::*; #(
    parameter int btbEntries = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] readPc_i,
    output logic            hit_o,
    output logic            isJump_o,
    output logic [xlen-1:0] target_o,
    input  logic            writeEn_i,
    input  logic [xlen-1:0] writePc_i,
    input  logic [xlen-1:0] writeTarget_i,
    input  logic            writeJump_i
);

    localparam int idxBits = $clog2(btbEntries);

    logic                  valid   [btbEntries];
    logic                  jumpBit [btbEntries];
    logic [xlen-1:0]       targets [btbEntries];
    logic [idxBits-1:0]    readIdx;
    logic [idxBits-1:0]    writeIdx;

    // Word index, byte offset dropped
    assign readIdx  = readPc_i[idxBits+1:2];
    assign writeIdx = writePc_i[idxBits+1:2];

    assign hit_o    = valid[readIdx];
    assign isJump_o = jumpBit[readIdx];
    assign target_o = targets[readIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < btbEntries; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (writeEn_i) begin
            valid[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn_i) begin
            jumpBit[writeIdx] <= writeJump_i;
            targets[writeIdx] <= writeTarget_i;
        end
    end

endmodule

`default_nettype wire

/* branchPredictor.sv */
/*
 * Gshare predictor: global history, counter table and target buffer.
 * Produces the fetch prediction and trains both tables from the resolve port.
 */
`timescale 1ns/1ps
`default_nettype none

module branchPredictor import fetchPkg::*; #(
    parameter int btbEntries = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [xlen-1:0]    pc_i,
    input  logic               instr0Branch_i,
    input  logic               stall_i,
    input  resolve_t           resolve_i,
    output logic               predTaken_o,
    output logic [xlen-1:0]    target_o,
    output logic [ghrBits-1:0] phtIndex_o,
    output logic               mispredict_o
);

    logic [ghrBits-1:0] ghr;
    logic               counterTaken;
    logic               btbHit;
    logic               btbJump;
    logic               resolveTaken;

    // Hash history with the word address
    assign phtIndex_o = ghr ^ pc_i[ghrBits+1:2];

    // Jumps in the buffer are always taken
    assign predTaken_o = btbHit && (btbJump || counterTaken);

    // Jumps count as taken
    assign resolveTaken = resolve_i.taken || resolve_i.isJump;

    assign mispredict_o = resolve_i.valid &&
        ((resolve_i.isJump && !resolve_i.predTaken) ||
         (resolve_i.isBranch && (resolve_i.predTaken != resolve_i.taken)));

    patternTable u_patternTable (
        .clk          (clk),
        .reset        (reset),
        .readIndex_i  (phtIndex_o),
        .taken_o      (counterTaken),
        .trainEn_i    (resolve_i.valid && resolve_i.isBranch),
        .trainIndex_i (resolve_i.phtIndex),
        .trainTaken_i (resolve_i.taken)
    );

    targetBuffer #(
        .btbEntries (btbEntries)
    ) u_targetBuffer (
        .clk           (clk),
        .reset         (reset),
        .readPc_i      (pc_i),
        .hit_o         (btbHit),
        .isJump_o      (btbJump),
        .target_o      (target_o),
        .writeEn_i     (resolve_i.valid && resolveTaken),
        .writePc_i     (resolve_i.pc),
        .writeTarget_i (resolve_i.target),
        .writeJump_i   (resolve_i.isJump)
    );

    // History restarts on a mispredict, frozen while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (mispredict_o) begin
            ghr <= '0;
        end else if (!stall_i && instr0Branch_i) begin
            ghr <= {ghr[ghrBits-2:0], predTaken_o};
        end
    end

endmodule

`default_nettype wire

/* fetchUnit.sv */
/*
 * Top of the dual-issue fetch end: PC register, next-PC choice and redirect.
 * Takes the fetched pair and a resolve report, drives the fetch bundle.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import fetchPkg::*; #(
    parameter logic [xlen-1:0] resetPc    = '0,
    parameter int              btbEntries = 32
) (
    input  logic       clk,
    input  logic       reset,
    input  fetchPair_t pair_i,
    input  logic       stall_i,
    input  resolve_t   resolve_i,
    output fetchOut_t  fetch_o
);

    logic [xlen-1:0]    pc;
    logic [xlen-1:0]    pcNext;
    logic [xlen-1:0]    pcStep;
    logic [xlen-1:0]    redirectPc;
    logic [xlen-1:0]    predTarget;
    logic [1:0]         issueCount;
    logic               predTaken;
    logic               mispredict;
    logic               instr0Branch;
    logic [ghrBits-1:0] phtIndex;

    assign instr0Branch = (pair_i.instr0[6:0] == opBranch);

    pairCheck u_pairCheck (
        .pair_i       (pair_i),
        .issueCount_o (issueCount)
    );

    branchPredictor #(
        .btbEntries (btbEntries)
    ) u_branchPredictor (
        .clk            (clk),
        .reset          (reset),
        .pc_i           (pc),
        .instr0Branch_i (instr0Branch),
        .stall_i        (stall_i),
        .resolve_i      (resolve_i),
        .predTaken_o    (predTaken),
        .target_o       (predTarget),
        .phtIndex_o     (phtIndex),
        .mispredict_o   (mispredict)
    );

    // Advance by one or two words
    assign pcStep = {{(xlen-4){1'b0}}, issueCount, 2'b00};

    // Recovery point, a jump always goes to its target
    assign redirectPc = (resolve_i.taken || resolve_i.isJump) ?
                        resolve_i.target : resolve_i.pc + 32'd4;

    always_comb begin
        if (mispredict) begin
            pcNext = redirectPc;
        end else if (stall_i) begin
            pcNext = pc;
        end else if (predTaken) begin
            pcNext = predTarget;
        end else begin
            pcNext = pc + pcStep;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;
        end
    end

    assign fetch_o = '{
        pc:         pc,
        issueCount: issueCount,
        predTaken:  predTaken,
        phtIndex:   phtIndex
    };

endmodule

`default_nettype wire

/* fetchChecker.sv */
/*
 * Mirrors the fetch unit's PC, history, counters and target buffer, and
 * compares fetch_o with the reference bundle at every rising edge.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchChecker import fetchPkg::*; #(
    parameter logic [xlen-1:0] resetPc    = '0,
    parameter int              btbEntries = 32
) (
    input  logic       clk,
    input  logic       reset,
    input  int         testId_i,
    input  fetchPair_t pair_i,
    input  logic       stall_i,
    input  resolve_t   resolve_i,
    input  fetchOut_t  fetch_i,
    output int         errorCount_o,
    output int         checkCount_o
);

    localparam int idxBits = $clog2(btbEntries);

    logic [xlen-1:0]    modelPc;
    logic [ghrBits-1:0] modelGhr;
    logic [1:0]         modelCnt [1 << ghrBits];
    logic               modelValid [btbEntries];
    logic               modelJump [btbEntries];
    logic [xlen-1:0]    modelTarget [btbEntries];
    logic               ready = 1'b0;
    int                 errors = 0;
    int                 checks = 0;

    assign errorCount_o = errors;
    assign checkCount_o = checks;

    function automatic string testName(input int id);
        case (id)
            1: return "resetStream";
            2: return "pairHazards";
            3: return "jalRedirect";
            4: return "branchTraining";
            5: return "stallHold";
            6: return "random";
            default: return "idle";
        endcase
    endfunction

    function automatic logic hasDest(input logic [6:0] op);
        return op inside {opLui, opJal, opJalr, opLoad, opRtype, opItype};
    endfunction

    // Reference bundle from the model state and the fetched pair
    function automatic fetchOut_t expectedFetch(input fetchPair_t pair);
        logic [6:0]         op0;
        logic [6:0]         op1;
        logic [4:0]         rd0;
        logic               split;
        logic [idxBits-1:0] slot;
        fetchOut_t          result;
        op0 = pair.instr0[6:0];
        op1 = pair.instr1[6:0];
        rd0 = pair.instr0[11:7];
        split = (op0 inside {opBranch, opJal, opJalr}) || (op1 inside {opBranch, opJal, opJalr});
        if (hasDest(op0) && (rd0 != 5'd0)) begin
            split |= (pair.instr1[19:15] == rd0);
            split |= (op1 inside {opRtype, opStore}) && (pair.instr1[24:20] == rd0);
            split |= hasDest(op1) && (pair.instr1[11:7] == rd0);
        end
        slot = modelPc[idxBits+1:2];
        result.pc = modelPc;
        result.issueCount = split ? 2'd1 : 2'd2;
        result.phtIndex = modelGhr ^ modelPc[ghrBits+1:2];
        result.predTaken = modelValid[slot] && (modelJump[slot] || modelCnt[result.phtIndex][1]);
        return result;
    endfunction

    function automatic logic [xlen-1:0] expectedNextPc(input fetchOut_t now, input logic redirect);
        if (redirect) begin
            // A jump resumes at its target whatever its taken bit says
            if (resolve_i.isJump) begin
                return resolve_i.target;
            end
            if (resolve_i.taken) begin
                return resolve_i.target;
            end
            return resolve_i.pc + 32'd4;
        end
        if (stall_i) begin
            return now.pc;
        end
        if (now.predTaken) begin
            return modelTarget[now.pc[idxBits+1:2]];
        end
        return now.pc + 32'(now.issueCount) * 32'd4;
    endfunction

    task automatic compareField(input string field, input logic [xlen-1:0] expected,
                                input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s %s expected %h actual %h",
                     testName(testId_i), field, expected, actual);
        end
    endtask

    always @(posedge clk) begin : compareStep
        fetchOut_t          expected;
        logic               mispredict;
        logic [idxBits-1:0] writeSlot;
        logic [1:0]         count;
        if (reset) begin
            ready    <= 1'b1;
            modelPc  <= resetPc;
            modelGhr <= '0;
            for (int i = 0; i < (1 << ghrBits); i++) begin
                modelCnt[i] <= 2'b01;
            end
            for (int i = 0; i < btbEntries; i++) begin
                modelValid[i] <= 1'b0;
            end
        end else if (ready) begin
            expected = expectedFetch(pair_i);
            compareField("pc", expected.pc, fetch_i.pc);
            compareField("issueCount", 32'(expected.issueCount), 32'(fetch_i.issueCount));
            compareField("predTaken", 32'(expected.predTaken), 32'(fetch_i.predTaken));
            compareField("phtIndex", 32'(expected.phtIndex), 32'(fetch_i.phtIndex));
            checks++;
            mispredict = resolve_i.valid && ((resolve_i.isJump && !resolve_i.predTaken) ||
                         (resolve_i.isBranch && (resolve_i.taken != resolve_i.predTaken)));
            // Taken branches and all jumps fill the buffer
            writeSlot = resolve_i.pc[idxBits+1:2];
            if (resolve_i.valid && (resolve_i.taken || resolve_i.isJump)) begin
                modelValid[writeSlot]  <= 1'b1;
                modelJump[writeSlot]   <= resolve_i.isJump;
                modelTarget[writeSlot] <= resolve_i.target;
            end
            count = modelCnt[resolve_i.phtIndex];
            if (resolve_i.valid && resolve_i.isBranch) begin
                if (resolve_i.taken && (count != 2'd3)) begin
                    modelCnt[resolve_i.phtIndex] <= count + 2'd1;
                end else if (!resolve_i.taken && (count != 2'd0)) begin
                    modelCnt[resolve_i.phtIndex] <= count - 2'd1;
                end
            end
            if (mispredict) begin
                modelGhr <= '0;
            end else if (!stall_i && (pair_i.instr0[6:0] == opBranch)) begin
                modelGhr <= {modelGhr[ghrBits-2:0], expected.predTaken};
            end
            modelPc <= expectedNextPc(expected, mispredict);
        end
    end

endmodule

`default_nettype wire

/* fetchUnit_props.sv */
/*
 * Concurrent checks on the fetch bundle that bind into every fetchUnit instance.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchUnitProps import fetchPkg::*; #(
    parameter logic [xlen-1:0] resetPc = '0
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_i,
    input  resolve_t  resolve_i,
    input  fetchOut_t fetch_i
);

    // With no stall, resolve or prediction the PC moves by the issued words
    pcAdvanceByIssue: assert property (@(posedge clk) disable iff (reset)
        (!stall_i && !resolve_i.valid && !fetch_i.predTaken) |=>
        (fetch_i.pc == $past(fetch_i.pc) + 32'($past(fetch_i.issueCount)) * 32'd4))
        else $error("pc %h did not advance by the issued words", fetch_i.pc);

    pcAfterReset: assert property (@(posedge clk) reset |=> (fetch_i.pc == resetPc))
        else $error("pc %h is not the reset pc after reset", fetch_i.pc);

    // A stall with no resolve must not move the PC
    pcHeldOnStall: assert property (@(posedge clk) disable iff (reset)
        (stall_i && !resolve_i.valid) |=> $stable(fetch_i.pc))
        else $error("pc moved to %h across a stall cycle", fetch_i.pc);

    pcAligned: assert property (@(posedge clk) disable iff (reset) fetch_i.pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", fetch_i.pc);

endmodule

bind fetchUnit fetchUnitProps #(.resetPc(resetPc)) u_props (
    .clk       (clk),
    .reset     (reset),
    .stall_i   (stall_i),
    .resolve_i (resolve_i),
    .fetch_i   (fetch_o)
);

`default_nettype wire

/* tb_dualFetch.sv */
/*
 * Testbench for the dual-issue fetch unit. Drives directed and random stimulus
 * on the falling edge; fetchChecker does the comparing.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dualFetch import fetchPkg::*; ();

    localparam logic [xlen-1:0] resetPc        = 32'h0000_0100;
    localparam int              btbEntries     = 32;
    localparam int              resetCycles    = 5;
    localparam int              directedCycles = 195;
    localparam int              randomCycles   = 300;
    // Four times the expected run length
    localparam int              timeoutCycles  = 4 * (resetCycles + directedCycles + randomCycles);
    localparam logic [31:0]     randomSeed     = 32'h6e982fc0;
    localparam resolve_t        noResolve      = '0;

    logic       clk;
    logic       reset;
    logic       stall;
    fetchPair_t pair;
    fetchPair_t aluPair;
    resolve_t   resolve;
    fetchOut_t  fetch;
    int         testId;
    int         mismatches;
    int         compared;
    int         otherErrors = 0;
    int         cycleCount = 0;

    fetchUnit #(
        .resetPc    (resetPc),
        .btbEntries (btbEntries)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .pair_i    (pair),
        .stall_i   (stall),
        .resolve_i (resolve),
        .fetch_o   (fetch)
    );

    fetchChecker #(
        .resetPc    (resetPc),
        .btbEntries (btbEntries)
    ) u_checker (
        .clk          (clk),
        .reset        (reset),
        .testId_i     (testId),
        .pair_i       (pair),
        .stall_i      (stall),
        .resolve_i    (resolve),
        .fetch_i      (fetch),
        .errorCount_o (mismatches),
        .checkCount_o (compared)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: run still going after %0d cycles", timeoutCycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Register fields at their fixed positions, other bits zero
    function automatic logic [31:0] instrWord(input logic [6:0] op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, op};
    endfunction

    function automatic fetchPair_t pairOf(input logic [31:0] first, input logic [31:0] second);
        return '{instr0: first, instr1: second};
    endfunction

    function automatic resolve_t resolveOf(input logic [xlen-1:0] pc, input logic isBranch,
                                           input logic isJump, input logic taken,
                                           input logic predTaken, input logic [xlen-1:0] target,
                                           input logic [ghrBits-1:0] pht);
        return '{valid: 1'b1, pc: pc, isBranch: isBranch, isJump: isJump, taken: taken,
                 predTaken: predTaken, target: target, phtIndex: pht};
    endfunction

    // Registers kept to x0..x3 so hazards come up often
    function automatic logic [31:0] randomWord();
        logic [31:0] bits;
        logic [6:0]  op;
        bits = $urandom;
        case (bits[17:15])
            3'd0: op = opBranch;
            3'd1: op = opJal;
            3'd2: op = opJalr;
            3'd3: op = opLui;
            3'd4: op = opLoad;
            3'd5: op = opStore;
            3'd6: op = opRtype;
            default: op = opItype;
        endcase
        return {bits[31:25], 3'b000, bits[4:3], 3'b000, bits[6:5], bits[14:12],
                3'b000, bits[8:7], op};
    endfunction

    function automatic resolve_t randomResolve(input logic [xlen-1:0] currentPc);
        logic [31:0] pick;
        pick = $urandom;
        if (pick[1:0] != 2'd0) begin
            return noResolve;
        end
        return resolveOf(pick[2] ? currentPc : ($urandom & 32'h0000_0ffc), pick[3], !pick[3],
                         pick[4], pick[5], $urandom & 32'h0000_0ffc, pick[10:6]);
    endfunction

    task automatic applyCycle(input fetchPair_t nextPair, input logic nextStall,
                              input resolve_t nextResolve);
        @(negedge clk);
        pair = nextPair;
        stall = nextStall;
        resolve = nextResolve;
    endtask

    initial begin
        logic [xlen-1:0]    jalPc;
        logic [xlen-1:0]    branchPc;
        logic [xlen-1:0]    stallPc;
        logic [ghrBits-1:0] branchPht;
        fetchPair_t         branchPair;
        void'($urandom(randomSeed));
        aluPair = pairOf(instrWord(opItype, 1, 2, 3), instrWord(opItype, 3, 4, 5));
        branchPair = pairOf(instrWord(opBranch, 0, 1, 2), instrWord(opItype, 6, 7, 0));
        reset = 1'b1;
        stall = 1'b0;
        pair = aluPair;
        resolve = noResolve;
        testId = 0;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;

        testId = 1;
        repeat (20) applyCycle(aluPair, 1'b0, noResolve);

        testId = 2;
        applyCycle(pairOf(instrWord(opRtype, 5, 1, 2), instrWord(opRtype, 6, 5, 3)), 0, noResolve);
        applyCycle(pairOf(instrWord(opRtype, 5, 1, 2), instrWord(opRtype, 6, 3, 5)), 0, noResolve);
        applyCycle(pairOf(instrWord(opLoad, 5, 1, 0), instrWord(opStore, 0, 3, 5)), 0, noResolve);
        applyCycle(pairOf(instrWord(opItype, 5, 1, 0), instrWord(opItype, 6, 7, 5)), 0, noResolve);
        applyCycle(pairOf(instrWord(opRtype, 5, 1, 2), instrWord(opRtype, 5, 3, 4)), 0, noResolve);
        applyCycle(branchPair, 0, noResolve);
        applyCycle(pairOf(instrWord(opItype, 1, 2, 0), instrWord(opBranch, 0, 3, 4)), 0, noResolve);
        applyCycle(pairOf(instrWord(opJal, 1, 0, 0), instrWord(opItype, 2, 3, 0)), 0, noResolve);
        applyCycle(pairOf(instrWord(opItype, 2, 3, 0), instrWord(opJalr, 1, 4, 0)), 0, noResolve);
        // Same register numbers through x0 never split the pair
        applyCycle(pairOf(instrWord(opRtype, 0, 1, 2), instrWord(opRtype, 6, 0, 0)), 0, noResolve);
        applyCycle(pairOf(instrWord(opRtype, 0, 1, 2), instrWord(opRtype, 0, 3, 4)), 0, noResolve);

        testId = 3;
        applyCycle(pairOf(instrWord(opJal, 1, 0, 0), instrWord(opItype, 2, 3, 0)), 0, noResolve);
        jalPc = fetch.pc;
        applyCycle(aluPair, 0, resolveOf(jalPc, 0, 1, 1, 0, 32'h0000_0400, '0));
        repeat (3) applyCycle(aluPair, 0, noResolve);
        // Jump back to the jal from a neighbouring buffer slot
        applyCycle(aluPair, 0, resolveOf(jalPc + 32'd4, 0, 1, 1, 0, jalPc, '0));
        applyCycle(pairOf(instrWord(opJal, 1, 0, 0), instrWord(opItype, 2, 3, 0)), 0, noResolve);
        repeat (3) applyCycle(aluPair, 0, noResolve);

        testId = 4;
        applyCycle(branchPair, 0, noResolve);
        branchPc = fetch.pc;
        branchPht = fetch.phtIndex;
        applyCycle(aluPair, 0, resolveOf(branchPc, 1, 0, 1, 0, 32'h0000_0600, branchPht));
        applyCycle(aluPair, 0, resolveOf(branchPc, 1, 0, 1, 1, 32'h0000_0600, branchPht));
        applyCycle(aluPair, 0, resolveOf(branchPc + 32'd12, 0, 1, 1, 0, branchPc, '0));
        applyCycle(branchPair, 0, noResolve);
        applyCycle(aluPair, 0, noResolve);
        applyCycle(aluPair, 0, resolveOf(branchPc, 1, 0, 0, 1, 32'h0000_0600, branchPht));
        repeat (4) applyCycle(aluPair, 0, noResolve);

        testId = 5;
        applyCycle(branchPair, 1, noResolve);
        stallPc = fetch.pc;
        applyCycle(branchPair, 1, resolveOf(stallPc, 1, 0, 1, 1, 32'h0000_0800, fetch.phtIndex));
        repeat (3) applyCycle(branchPair, 1, noResolve);
        applyCycle(branchPair, 0, noResolve);
        repeat (3) applyCycle(aluPair, 0, noResolve);

        testId = 6;
        for (int i = 0; i < randomCycles; i++) begin
            applyCycle(pairOf(randomWord(), randomWord()), ($urandom % 5) == 0,
                       randomResolve(fetch.pc));
        end

        testId = 0;
        applyCycle(aluPair, 0, noResolve);
        repeat (2) @(negedge clk);
        if (compared == 0) begin
            otherErrors++;
            $display("The checker compared no cycles, so the DUT output was never checked");
        end
        $display("Closing: %0d mismatches, %0d other failures, %0d cycles compared",
                 mismatches, otherErrors, compared);
        if ((mismatches + otherErrors) == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dualFetch.f */
fetchPkg.sv
pairCheck.sv
patternTable.sv
targetBuffer.sv
branchPredictor.sv
fetchUnit.sv
fetchChecker.sv
fetchUnit_props.sv
tb_dualFetch.sv

/* run.sh */
#!/bin/sh
# Builds the fetch unit testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_dualFetch \
    -f dualFetch.f -o simDualFetch > build.log 2>&1 &&
{ ./obj_dir/simDualFetch > sim.log 2>&1; cat sim.log; } &&
! grep -q "TESTS FAILED" sim.log &&
grep -q "TESTS PASSED" sim.log &&
echo "Run finished cleanly" ||
{ echo "Run failed, see build.log and sim.log"; exit 1; }
